// ==== neuron_params.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// neuron core parameters
// index widths, word width and weight log depth
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef NEURON_PARAMS_SVH
`define NEURON_PARAMS_SVH

// 16 neurons per core
`define NURN_CNT_BITS 4

// 16 axons per neuron
`define AXON_CNT_BITS 4

// state and weight word width
`define DSIZE 16

// 256 entries, one full step of weights
`define WFIFO_AW 8
`endif

// ==== neuron_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// neuron core shared types
// index, address and word types, host select and fetch FSM encodings
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "neuron_params.svh"

package neuron_pkg;
	typedef logic [`NURN_CNT_BITS-1:0] neuron_id_t;
	typedef logic [`AXON_CNT_BITS-1:0] axon_id_t;
	// neuron index above axon index
	typedef logic [`NURN_CNT_BITS+`AXON_CNT_BITS-1:0] syn_addr_t;
	typedef logic signed [`DSIZE-1:0] state_word_t;
	typedef logic [(1<<`AXON_CNT_BITS)-1:0] axon_mask_t;

	// host access target
	typedef enum logic [1:0] {SEL_BIAS, SEL_POTENTIAL, SEL_THRESHOLD, SEL_WEIGHT} mem_sel_e;

	typedef enum logic [1:0] {FETCH_IDLE, FETCH_SCAN, FETCH_DRAIN} fetch_state_e;
endpackage

// ==== weight_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// weight log FIFO
// single clock circular buffer, cleared at the start of each step
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "neuron_params.svh"

module weight_fifo
	import neuron_pkg::*;
(
	input  logic        clk_i,
	input  logic        rst_n_i,
	input  logic        clr_i,
	input  logic        we_i,
	input  state_word_t din_i,
	input  logic        re_i,
	output state_word_t dout_o,
	output logic        empty_o,
	output logic        full_o
);
	localparam int DEPTH = 1 << `WFIFO_AW;

	state_word_t          mem [DEPTH];
	logic [`WFIFO_AW-1:0] wr_ptr;
	logic [`WFIFO_AW-1:0] rd_ptr;
	logic [`WFIFO_AW:0]   count;
	logic                 do_wr;
	logic                 do_rd;

	assign empty_o = (count == '0);
	// top count bit alone means DEPTH entries
	assign full_o = count[`WFIFO_AW];
	assign do_wr = we_i && !full_o;
	assign do_rd = re_i && !empty_o;

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else if (clr_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (do_wr)
			mem[wr_ptr] <= din_i;
		if (do_rd)
			dout_o <= mem[rd_ptr];
	end

	a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		we_i |-> !full_o)
		else $error("weight FIFO write while full");

	a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		re_i |-> !empty_o)
		else $error("weight FIFO read while empty");
endmodule

// ==== status_mem.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// neuron status memory
// bias, potential, threshold and synapse weight storage with host access,
// plus the log of every weight fetched during a step
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "neuron_params.svh"

module status_mem
	import neuron_pkg::*;
(
	input  logic        clk_i,
	input  logic        rst_n_i,
	input  logic        start_i,
	input  logic        cfg_we_i,
	input  logic        cfg_re_i,
	input  mem_sel_e    cfg_sel_i,
	input  syn_addr_t   cfg_addr_i,
	input  state_word_t cfg_data_i,
	output state_word_t rd_data_o,
	input  logic        busy_i,
	input  logic        w_rd_en_i,
	input  syn_addr_t   w_rd_addr_i,
	output state_word_t w_rd_data_o,
	input  logic        st_rd_en_i,
	input  neuron_id_t  st_rd_nid_i,
	output state_word_t bias_o,
	output state_word_t pot_o,
	output state_word_t thr_o,
	input  logic        st_wr_en_i,
	input  neuron_id_t  st_wr_nid_i,
	input  state_word_t st_wr_pot_i,
	input  logic        wfifo_rd_i,
	output state_word_t wfifo_data_o,
	output logic        wfifo_empty_o
);
	localparam int NUM_NURNS = 1 << `NURN_CNT_BITS;
	localparam int NUM_SYNS = 1 << (`NURN_CNT_BITS + `AXON_CNT_BITS);

	state_word_t mem_bias [NUM_NURNS];
	state_word_t mem_pot [NUM_NURNS];
	state_word_t mem_thr [NUM_NURNS];
	state_word_t mem_weight [NUM_SYNS];

	neuron_id_t  st_raddr;
	syn_addr_t   w_raddr;
	mem_sel_e    rd_sel;
	neuron_id_t  cfg_nid;
	logic        wfifo_we;

	assign cfg_nid = cfg_addr_i[`NURN_CNT_BITS-1:0];

	// read addresses are shared, the host only reads while the core is idle
	always_ff @(posedge clk_i)
	begin
		if (cfg_re_i)
		begin
			st_raddr <= cfg_nid;
			w_raddr <= cfg_addr_i;
			rd_sel <= cfg_sel_i;
		end
		else
		begin
			if (st_rd_en_i)
				st_raddr <= st_rd_nid_i;
			if (w_rd_en_i)
				w_raddr <= w_rd_addr_i;
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (cfg_we_i && cfg_sel_i == SEL_BIAS)
			mem_bias[cfg_nid] <= cfg_data_i;
		if (cfg_we_i && cfg_sel_i == SEL_THRESHOLD)
			mem_thr[cfg_nid] <= cfg_data_i;
		if (cfg_we_i && cfg_sel_i == SEL_WEIGHT)
			mem_weight[cfg_addr_i] <= cfg_data_i;
		// pipeline write-back wins over the host
		if (st_wr_en_i)
			mem_pot[st_wr_nid_i] <= st_wr_pot_i;
		else if (cfg_we_i && cfg_sel_i == SEL_POTENTIAL)
			mem_pot[cfg_nid] <= cfg_data_i;
	end

	assign bias_o = mem_bias[st_raddr];
	assign pot_o = mem_pot[st_raddr];
	assign thr_o = mem_thr[st_raddr];
	assign w_rd_data_o = mem_weight[w_raddr];

	always_comb
	begin
		case (rd_sel)
			SEL_BIAS:      rd_data_o = bias_o;
			SEL_POTENTIAL: rd_data_o = pot_o;
			SEL_THRESHOLD: rd_data_o = thr_o;
			default:       rd_data_o = w_rd_data_o;
		endcase
	end

	// log the weight on the cycle it leaves the memory
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
			wfifo_we <= 1'b0;
		else
			wfifo_we <= w_rd_en_i;
	end

	weight_fifo u_weight_fifo (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.clr_i   (start_i),
		.we_i    (wfifo_we),
		.din_i   (w_rd_data_o),
		.re_i    (wfifo_rd_i),
		.dout_o  (wfifo_data_o),
		.empty_o (wfifo_empty_o),
		.full_o  ()
	);

	a_host_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		busy_i |-> !(cfg_we_i || cfg_re_i))
		else $error("host access while the core is busy");
endmodule

// ==== synapse_fetch.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// synapse fetch sequencer
// walks every neuron and axon of a step and reads weights of spiking axons
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module synapse_fetch
	import neuron_pkg::*;
(
	input  logic       clk_i,
	input  logic       rst_n_i,
	input  logic       start_i,
	input  axon_mask_t spike_mask_i,
	output logic       w_rd_en_o,
	output syn_addr_t  w_rd_addr_o,
	output logic       acc_en_o,
	output logic       acc_last_o,
	output neuron_id_t acc_nid_o,
	output logic       busy_o
);
	// drain counts 0..2 on the axon counter
	localparam axon_id_t DRAIN_LAST = axon_id_t'(2);

	fetch_state_e state;
	neuron_id_t   nid;
	axon_id_t     aid;
	axon_mask_t   mask;
	logic         scan;

	assign scan = (state == FETCH_SCAN);

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			state <= FETCH_IDLE;
			nid <= '0;
			aid <= '0;
		end
		else
		begin
			case (state)
				FETCH_IDLE:
				begin
					if (start_i)
						state <= FETCH_SCAN;
				end
				FETCH_SCAN:
				begin
					// one cycle per axon, spiking or not
					aid <= aid + 1'b1;
					if (aid == '1)
					begin
						nid <= nid + 1'b1;
						if (nid == '1)
							state <= FETCH_DRAIN;
					end
				end
				FETCH_DRAIN:
				begin
					aid <= aid + 1'b1;
					if (aid == DRAIN_LAST)
					begin
						aid <= '0;
						state <= FETCH_IDLE;
					end
				end
				default: state <= FETCH_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (start_i && state == FETCH_IDLE)
			mask <= spike_mask_i;
	end

	assign w_rd_en_o = scan && mask[aid];
	assign w_rd_addr_o = {nid, aid};
	assign acc_en_o = w_rd_en_o;
	assign acc_last_o = scan && (aid == '1);
	assign acc_nid_o = nid;
	assign busy_o = (state != FETCH_IDLE);

	a_start_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		busy_o |-> !start_i)
		else $error("start while a step is running");
endmodule

// ==== neuron_update.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// neuron accumulate and update stage
// sums fetched weights, leaks bias into the potential, fires on threshold
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "neuron_params.svh"

module neuron_update
	import neuron_pkg::*;
(
	input  logic        clk_i,
	input  logic        rst_n_i,
	input  logic        acc_en_i,
	input  logic        acc_last_i,
	input  neuron_id_t  acc_nid_i,
	input  state_word_t w_rd_data_i,
	output logic        st_rd_en_o,
	output neuron_id_t  st_rd_nid_o,
	input  state_word_t bias_i,
	input  state_word_t pot_i,
	input  state_word_t thr_i,
	output logic        st_wr_en_o,
	output neuron_id_t  st_wr_nid_o,
	output state_word_t st_wr_pot_o,
	output logic        spike_valid_o,
	output neuron_id_t  spike_id_o,
	output logic        done_o
);
	// room for 16 full scale weights, then bias and potential on top
	localparam int ACC_W = `DSIZE + `AXON_CNT_BITS;
	localparam int SUM_W = ACC_W + 2;
	localparam logic signed [SUM_W-1:0] POT_MAX = (1 << (`DSIZE - 1)) - 1;
	localparam logic signed [SUM_W-1:0] POT_MIN = -(1 << (`DSIZE - 1));

	logic                    acc_en_d;
	logic                    acc_last_d;
	neuron_id_t              acc_nid_d;
	logic signed [ACC_W-1:0] acc_sum;
	logic signed [ACC_W-1:0] acc_add;
	logic signed [ACC_W-1:0] sum_next;
	logic signed [ACC_W-1:0] sum_lat;
	logic                    upd_vld;
	neuron_id_t              upd_nid;
	logic signed [SUM_W-1:0] total;
	state_word_t             new_pot;
	logic                    fire;

	always_comb
	begin
		acc_add = '0;
		if (acc_en_d)
			acc_add = ACC_W'(w_rd_data_i);
		sum_next = acc_sum + acc_add;
	end

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			acc_en_d <= 1'b0;
			acc_last_d <= 1'b0;
			acc_sum <= '0;
			upd_vld <= 1'b0;
			st_wr_en_o <= 1'b0;
			spike_valid_o <= 1'b0;
			done_o <= 1'b0;
		end
		else
		begin
			// weight data arrives one cycle after the fetch
			acc_en_d <= acc_en_i;
			acc_last_d <= acc_last_i;
			acc_sum <= acc_last_d ? '0 : sum_next;
			upd_vld <= acc_last_d;
			st_wr_en_o <= upd_vld;
			spike_valid_o <= upd_vld && fire;
			done_o <= upd_vld && (upd_nid == '1);
		end
	end

	always_ff @(posedge clk_i)
	begin
		acc_nid_d <= acc_nid_i;
		if (acc_last_d)
		begin
			sum_lat <= sum_next;
			upd_nid <= acc_nid_d;
		end
		st_wr_nid_o <= upd_nid;
		spike_id_o <= upd_nid;
		st_wr_pot_o <= fire ? '0 : new_pot;
	end

	// state read is issued with the closing sum
	assign st_rd_en_o = acc_last_d;
	assign st_rd_nid_o = acc_nid_d;

	always_comb
	begin
		total = SUM_W'(pot_i) + SUM_W'(bias_i) + SUM_W'(sum_lat);
		if (total > POT_MAX)
			new_pot = state_word_t'(POT_MAX);
		else if (total < POT_MIN)
			new_pot = state_word_t'(POT_MIN);
		else
			new_pot = state_word_t'(total);
		fire = (new_pot >= thr_i);
	end
endmodule

// ==== neuron_core_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spiking neuron core
// fetch, accumulate and update pipeline around the status memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module neuron_core_top
	import neuron_pkg::*;
(
	input  logic        clk_i,
	input  logic        rst_n_i,
	input  logic        start_i,
	input  axon_mask_t  spike_mask_i,
	input  logic        cfg_we_i,
	input  logic        cfg_re_i,
	input  mem_sel_e    cfg_sel_i,
	input  syn_addr_t   cfg_addr_i,
	input  state_word_t cfg_data_i,
	output state_word_t rd_data_o,
	output logic        spike_valid_o,
	output neuron_id_t  spike_id_o,
	output logic        busy_o,
	output logic        done_o,
	input  logic        wfifo_rd_i,
	output state_word_t wfifo_data_o,
	output logic        wfifo_empty_o
);
	logic        w_rd_en, acc_en, acc_last, st_rd_en, st_wr_en;
	syn_addr_t   w_rd_addr;
	neuron_id_t  acc_nid, st_rd_nid, st_wr_nid;
	state_word_t w_rd_data, bias, pot, thr, st_wr_pot;

	synapse_fetch u_fetch (.clk_i, .rst_n_i, .start_i, .spike_mask_i,
		.w_rd_en_o(w_rd_en), .w_rd_addr_o(w_rd_addr), .acc_en_o(acc_en),
		.acc_last_o(acc_last), .acc_nid_o(acc_nid), .busy_o);

	neuron_update u_update (.clk_i, .rst_n_i, .acc_en_i(acc_en), .acc_last_i(acc_last),
		.acc_nid_i(acc_nid), .w_rd_data_i(w_rd_data), .st_rd_en_o(st_rd_en),
		.st_rd_nid_o(st_rd_nid), .bias_i(bias), .pot_i(pot), .thr_i(thr),
		.st_wr_en_o(st_wr_en), .st_wr_nid_o(st_wr_nid), .st_wr_pot_o(st_wr_pot),
		.spike_valid_o, .spike_id_o, .done_o);

	status_mem u_status_mem (.clk_i, .rst_n_i, .start_i, .cfg_we_i, .cfg_re_i,
		.cfg_sel_i, .cfg_addr_i, .cfg_data_i, .rd_data_o, .busy_i(busy_o),
		.w_rd_en_i(w_rd_en), .w_rd_addr_i(w_rd_addr), .w_rd_data_o(w_rd_data),
		.st_rd_en_i(st_rd_en), .st_rd_nid_i(st_rd_nid), .bias_o(bias), .pot_o(pot),
		.thr_o(thr), .st_wr_en_i(st_wr_en), .st_wr_nid_i(st_wr_nid),
		.st_wr_pot_i(st_wr_pot), .wfifo_rd_i, .wfifo_data_o, .wfifo_empty_o);
endmodule

// ==== tb_neuron_core.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// neuron core testbench
// replays host writes and steps from the vectors file
// and checks spikes, potentials and the weight log
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_neuron_core
	import neuron_pkg::*;
();
	// one cycle per synapse, then the update tail
	localparam int STEP_CYCLES = (1 << $bits(neuron_id_t)) * (1 << $bits(axon_id_t)) + 3;

	logic        clk_i;
	logic        rst_n_i;
	logic        start_i;
	axon_mask_t  spike_mask_i;
	logic        cfg_we_i;
	logic        cfg_re_i;
	mem_sel_e    cfg_sel_i;
	syn_addr_t   cfg_addr_i;
	state_word_t cfg_data_i;
	state_word_t rd_data_o;
	logic        spike_valid_o;
	neuron_id_t  spike_id_o;
	logic        busy_o;
	logic        done_o;
	logic        wfifo_rd_i;
	state_word_t wfifo_data_o;
	logic        wfifo_empty_o;

	// decoded vector records, op code followed by its fields
	int unsigned prog [$];
	neuron_id_t  spikes [$];
	int          steps;
	int          host_ops;
	int          wd_limit;
	integer      seed;

	neuron_core_top DUT (.*);

	always #4 clk_i = ~clk_i;

	task automatic abort_run();
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_state(input string name, input state_word_t exp, input state_word_t act);
		if (act !== exp)
		begin
			$display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_spike(input int idx, input neuron_id_t exp, input neuron_id_t act);
		if (act !== exp)
		begin
			$display("[FAIL] t=%0t spike_id_o[%0d] expected %0d got %0d", $time, idx, exp, act);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("[FAIL] t=%0t %s expected %b got %b", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic idle_gap();
		int gap;
		gap = $random(seed) & 1;
		repeat (gap)
		begin
			@(posedge clk_i);
			#1;
		end
	endtask

	task automatic host_write(input int sel, input int addr, input int data);
		cfg_we_i = 1'b1;
		cfg_sel_i = mem_sel_e'(sel[1:0]);
		cfg_addr_i = syn_addr_t'(addr);
		cfg_data_i = state_word_t'(data);
		@(posedge clk_i);
		#1;
		cfg_we_i = 1'b0;
	endtask

	// read data shows up on the cycle after the read strobe
	task automatic host_readback(input int sel, input int addr, input int exp);
		cfg_re_i = 1'b1;
		cfg_sel_i = mem_sel_e'(sel[1:0]);
		cfg_addr_i = syn_addr_t'(addr);
		@(posedge clk_i);
		#1;
		cfg_re_i = 1'b0;
		@(negedge clk_i);
		check_state("rd_data_o", state_word_t'(exp), rd_data_o);
		@(posedge clk_i);
		#1;
	endtask

	// every word follows its own index, thresholds well above the leak
	task automatic fill_memories();
		for (int n = 0; n < (1 << $bits(neuron_id_t)); n++)
		begin
			host_write(SEL_BIAS, n, n);
			host_write(SEL_POTENTIAL, n, n);
			host_write(SEL_THRESHOLD, n, 'h1000 + n);
		end
		for (int a = 0; a < (1 << $bits(syn_addr_t)); a++)
			host_write(SEL_WEIGHT, a, a);
	endtask

	task automatic run_step(input int mask);
		int cycles;
		spikes.delete();
		cycles = 0;
		start_i = 1'b1;
		spike_mask_i = axon_mask_t'(mask);
		@(posedge clk_i);
		#1;
		start_i = 1'b0;
		// busy from the cycle after start up to and including done
		do
		begin
			@(negedge clk_i);
			check_flag("busy_o", 1'b1, busy_o);
			cycles++;
			if (cycles > 400)
			begin
				$display("step did not finish, no done_o pulse within 400 cycles");
				abort_run();
			end
		end
		while (!done_o);
		if (cycles != STEP_CYCLES)
		begin
			$display("[FAIL] t=%0t done_o cycle expected %0d got %0d",
				$time, STEP_CYCLES, cycles);
			abort_run();
		end
		@(negedge clk_i);
		check_flag("busy_o", 1'b0, busy_o);
		check_flag("done_o", 1'b0, done_o);
		@(posedge clk_i);
		#1;
	endtask

	task automatic fifo_pop_check(input int exp);
		check_flag("wfifo_empty_o", 1'b0, wfifo_empty_o);
		wfifo_rd_i = 1'b1;
		@(posedge clk_i);
		#1;
		wfifo_rd_i = 1'b0;
		@(negedge clk_i);
		check_state("wfifo_data_o", state_word_t'(exp), wfifo_data_o);
		@(posedge clk_i);
		#1;
	endtask

	task automatic load_vectors();
		int         fd;
		int         got;
		int         cnt;
		int         a;
		int         b;
		int         c;
		logic [7:0] op;
		string      line;
		fd = $fopen("neuron_vectors.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open neuron_vectors.txt");
			abort_run();
		end
		while ($fscanf(fd, " %c", op) == 1)
		begin
			case (op)
				"#": got = $fgets(line, fd);
				"I":
				begin
					prog.push_back(op);
					host_ops += 3 * (1 << $bits(neuron_id_t)) + (1 << $bits(syn_addr_t));
				end
				"W", "R":
				begin
					got = $fscanf(fd, "%h %h %h", a, b, c);
					if (got != 3)
					begin
						$display("host record in the vectors file is missing fields");
						abort_run();
					end
					prog.push_back(op);
					prog.push_back(a);
					prog.push_back(b);
					prog.push_back(c);
					host_ops++;
				end
				"S", "E":
				begin
					got = $fscanf(fd, "%h", a);
					prog.push_back(op);
					prog.push_back(a);
					if (op == "S")
						steps++;
				end
				"P", "F":
				begin
					got = $fscanf(fd, "%d", cnt);
					prog.push_back(op);
					prog.push_back(cnt);
					for (int i = 0; i < cnt; i++)
					begin
						got = $fscanf(fd, "%h", a);
						prog.push_back(a);
					end
					if (op == "F")
						host_ops += cnt;
				end
				default:
				begin
					$display("unknown record type in the vectors file");
					abort_run();
				end
			endcase
		end
		$fclose(fd);
	endtask

	// spikes are only legal inside a step
	always @(negedge clk_i)
	begin
		if (rst_n_i && spike_valid_o)
		begin
			if (!busy_o)
			begin
				$display("spike_valid_o pulsed while no step was running");
				abort_run();
			end
			spikes.push_back(spike_id_o);
		end
	end

	initial
	begin
		wait (wd_limit > 0);
		repeat (wd_limit) @(posedge clk_i);
		$display("watchdog expired after %0d cycles, the run hung", wd_limit);
		abort_run();
	end

	initial
	begin
		int pc;
		int op;
		int cnt;
		clk_i = 1'b0;
		rst_n_i = 1'b0;
		start_i = 1'b0;
		spike_mask_i = '0;
		cfg_we_i = 1'b0;
		cfg_re_i = 1'b0;
		cfg_sel_i = SEL_BIAS;
		cfg_addr_i = '0;
		cfg_data_i = '0;
		wfifo_rd_i = 1'b0;
		seed = 32'hfc98_3995;
		steps = 0;
		host_ops = 0;
		wd_limit = 0;
		load_vectors();
		wd_limit = steps * 300 + host_ops * 4 + 100;

		repeat (4) @(posedge clk_i);
		#1;
		rst_n_i = 1'b1;
		@(negedge clk_i);
		check_flag("busy_o", 1'b0, busy_o);
		check_flag("done_o", 1'b0, done_o);
		check_flag("spike_valid_o", 1'b0, spike_valid_o);
		check_flag("wfifo_empty_o", 1'b1, wfifo_empty_o);
		@(posedge clk_i);
		#1;

		pc = 0;
		while (pc < prog.size())
		begin
			op = prog[pc];
			case (op)
				"I":
				begin
					fill_memories();
					pc += 1;
				end
				"W":
				begin
					host_write(prog[pc + 1], prog[pc + 2], prog[pc + 3]);
					idle_gap();
					pc += 4;
				end
				"R":
				begin
					host_readback(prog[pc + 1], prog[pc + 2], prog[pc + 3]);
					idle_gap();
					pc += 4;
				end
				"S":
				begin
					run_step(prog[pc + 1]);
					pc += 2;
				end
				"E":
				begin
					check_flag("wfifo_empty_o", prog[pc + 1] != 0, wfifo_empty_o);
					pc += 2;
				end
				"P":
				begin
					cnt = prog[pc + 1];
					if (spikes.size() != cnt)
					begin
						$display("[FAIL] t=%0t spike count expected %0d got %0d",
							$time, cnt, spikes.size());
						abort_run();
					end
					for (int i = 0; i < cnt; i++)
						check_spike(i, neuron_id_t'(prog[pc + 2 + i]), spikes[i]);
					pc += 2 + cnt;
				end
				default:
				begin
					cnt = prog[pc + 1];
					for (int i = 0; i < cnt; i++)
						fifo_pop_check(prog[pc + 2 + i]);
					pc += 2 + cnt;
				end
			endcase
		end

		$display("sim passed");
		$finish;
	end
endmodule

// ==== compile.f ====
+incdir+.
neuron_pkg.sv
weight_fifo.sv
status_mem.sv
synapse_fetch.sv
neuron_update.sv
neuron_core_top.sv
tb_neuron_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the neuron core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	-f compile.f --top-module tb_neuron_core -o Vtb_neuron_core

# the log decides pass or fail, so a failing run must not stop the script here
./obj_dir/Vtb_neuron_core > sim.log 2>&1 || true
cat sim.log

if grep -qx "sim passed" sim.log
then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi

// ==== neuron_vectors.txt ====
# W sel addr data writes a word and R sel addr data expects it back (sel 0 bias 1 pot 2 thr 3 weight)
# I fills all memories, S mask runs a step, P n ids lists spikes, F n words pops the FIFO, E flag
I
W 0 03 0020
W 2 03 0020
W 1 07 0100
W 2 0a 0200
W 3 51 7000
W 3 56 7000
W 3 c1 8000
W 3 c6 8000
R 0 03 0020
R 2 03 0020
R 1 07 0100
R 2 0a 0200
R 3 51 7000
R 3 c6 8000
R 3 a6 00a6
# step 1 leaks bias only
S 0000
P 1 3
E 1
R 1 03 0000
R 1 04 0008
R 1 07 0107
# step 2 on axons 1 and 6, neuron 5 saturates high and neuron 12 low
S 0042
P 2 3 5
F 30 0001 0006 0011 0016 0021 0026 0031 0036 0041 0046 7000 7000 0061 0066 0071 0076
 0081 0086 0091 0096 00a1 00a6 00b1 00b6 8000 8000 00d1 00d6 00e1 00e6
E 0
R 1 05 0000
R 1 07 01f5
R 1 0a 0165
R 1 0c 8000
R 1 0f 0214
# step 3 on axon 15 drops the two leftover words
S 8000
P 2 3 a
F 16 000f 001f 002f 003f 004f 005f 006f 007f 008f 009f 00af 00bf 00cf 00df 00ef 00ff
E 1
R 1 05 0064
R 1 07 027b
R 1 0a 0000
R 1 0c 80db
